// ==== hdl/ahbPkg.sv ====
package ahbPkg;

  // bus widths
  localparam int ADDR_W = 32;
  localparam int DATA_W = 32;

  // haddr bit that picks the io region over memory
  localparam int REGION_BIT = 31;

  // transfer size as carried on hsize
  typedef enum logic [2:0] {
    SIZE_BYTE = 3'd0,
    SIZE_HALF = 3'd1,
    SIZE_WORD = 3'd2
  } hsizeE;

  // io register word offsets, taken from haddr[4:2]
  localparam int REG_IDX_W = 3;

  // write loads and starts the timer
  localparam logic [REG_IDX_W-1:0] REG_TIMER_LOAD = 3'd0;
  // current count, read only
  localparam logic [REG_IDX_W-1:0] REG_TIMER_VALUE = 3'd1;
  // pending sources, write one to clear
  localparam logic [REG_IDX_W-1:0] REG_INT_STATUS = 3'd2;
  // per source enable
  localparam logic [REG_IDX_W-1:0] REG_INT_ENABLE = 3'd3;
  // one sends the source to fiq instead of irq
  localparam logic [REG_IDX_W-1:0] REG_INT_FIQSEL = 3'd4;
  // write one to raise a status bit by software
  localparam logic [REG_IDX_W-1:0] REG_SOFT_INT = 3'd5;

  // interrupt source numbering
  localparam int SRC_TIMER = 0;
  // also the width of every interrupt register
  localparam int NUM_SRC = 8;

endpackage

// ==== hdl/slaveBus.sv ====
`timescale 1ns/1ps

interface slaveBus ();
  import ahbPkg::*;

  // request side, driven by the router
  logic              sel;
  logic              write;
  hsizeE             size;
  logic [ADDR_W-1:0] addr;
  logic [DATA_W-1:0] wdata;

  // response side, driven by the slave
  logic [DATA_W-1:0] rdata;
  logic              ready;

  modport router (
    output sel, write, size, addr, wdata,
    input  rdata, ready
  );

  // memory sequencing only needs the handshake
  modport memCtrl (
    input  sel, write,
    output ready
  );

  // memory array sees the payload
  modport memData (
    input  addr, size, wdata, write,
    output rdata
  );

  // io registers ignore size
  modport ioSlave (
    input  sel, write, addr, wdata,
    output rdata, ready
  );

endinterface

// ==== hdl/busRouter.sv ====
`timescale 1ns/1ps

module busRouter (
  input  logic                       HREQUEST,
  input  logic                       HWRITE,
  input  ahbPkg::hsizeE              HSIZE,
  input  logic [ahbPkg::ADDR_W-1:0]  HADDR,
  input  logic [ahbPkg::DATA_W-1:0]  HWDATA,
  output logic [ahbPkg::DATA_W-1:0]  HRDATA,
  output logic                       HREADY,
  slaveBus.router                    memBus,
  slaveBus.router                    ioBus
);
  import ahbPkg::*;

  logic ioRegion;

  // top address bit splits memory and io
  assign ioRegion = HADDR[REGION_BIT];

  // only the addressed slave sees the request
  assign memBus.sel = HREQUEST && !ioRegion;
  assign ioBus.sel  = HREQUEST && ioRegion;

  // payload goes to both slaves unchanged
  assign memBus.write = HWRITE;
  assign memBus.size  = HSIZE;
  assign memBus.addr  = HADDR;
  assign memBus.wdata = HWDATA;

  assign ioBus.write = HWRITE;
  assign ioBus.size  = HSIZE;
  assign ioBus.addr  = HADDR;
  assign ioBus.wdata = HWDATA;

  // response mux
  always_comb begin
    if (!HREQUEST) begin
      // idle bus reports ready with no data
      HRDATA = '0;
      HREADY = 1'b1;
    end else if (ioRegion) begin
      HRDATA = ioBus.rdata;
      HREADY = ioBus.ready;
    end else begin
      HRDATA = memBus.rdata;
      HREADY = memBus.ready;
    end
  end

endmodule

// ==== hdl/memAccessFsm.sv ====
`timescale 1ns/1ps

module memAccessFsm #(
  parameter int MEM_WAIT = 2
) (
  input  logic      HCLK,
  input  logic      arstN,
  slaveBus.memCtrl  bus,
  output logic      load,
  output logic      commit,
  input  logic      done
);

  typedef enum logic [1:0] {
    IDLE,
    WAIT,
    ACCESS
  } stateE;

  stateE state;
  stateE nextState;

  always_ff @(posedge HCLK or negedge arstN) begin
    if (!arstN) begin
      state <= IDLE;
    end else begin
      state <= nextState;
    end
  end

  always_comb begin
    nextState = state;
    case (state)
      IDLE: begin
        // new request starts the wait period
        if (bus.sel) begin
          nextState = WAIT;
        end
      end
      WAIT: begin
        // zero wait states never hold here
        if (done || (MEM_WAIT == 0)) begin
          nextState = ACCESS;
        end
      end
      ACCESS: begin
        // one idle cycle before the next request
        nextState = IDLE;
      end
      default: begin
        nextState = IDLE;
      end
    endcase
  end

  // counter is loaded as the request is first seen
  assign load = (state == IDLE) && bus.sel;

  // single ready cycle, write lands at its end
  assign bus.ready = (state == ACCESS);
  assign commit    = (state == ACCESS) && bus.write;

endmodule

// ==== hdl/waitCounter.sv ====
`timescale 1ns/1ps

module waitCounter #(
  parameter int MEM_WAIT = 2
) (
  input  logic HCLK,
  input  logic arstN,
  input  logic load,
  output logic done
);

  // load cycle already counts as one wait state
  localparam logic [3:0] START = (MEM_WAIT > 0) ? 4'(MEM_WAIT - 1) : 4'd0;

  logic [3:0] count;

  always_ff @(posedge HCLK or negedge arstN) begin
    if (!arstN) begin
      count <= '0;
    end else if (load) begin
      count <= START;
    end else if (count != '0) begin
      // holds at zero
      count <= count - 4'd1;
    end
  end

  // a pending load hides a stale zero
  assign done = (count == '0) && !load;

endmodule

// ==== hdl/dataMem.sv ====
`timescale 1ns/1ps

module dataMem #(
  parameter int MEM_WORDS = 1024
) (
  input  logic      HCLK,
  input  logic      commit,
  slaveBus.memData  bus
);
  import ahbPkg::*;

  localparam int IDX_W = $clog2(MEM_WORDS);
  localparam int LANES = DATA_W / 8;

  logic [DATA_W-1:0] mem [MEM_WORDS];
  logic [IDX_W-1:0]  idx;
  logic [LANES-1:0]  laneEn;

  // word index, upper address bits alias
  assign idx = bus.addr[IDX_W+1:2];

  // byte lanes from size and low address bits
  always_comb begin
    laneEn = '0;
    if (commit && bus.write) begin
      case (bus.size)
        SIZE_BYTE: begin
          laneEn = 4'b0001 << bus.addr[1:0];
        end
        SIZE_HALF: begin
          // bit 1 picks upper or lower half
          laneEn = bus.addr[1] ? 4'b1100 : 4'b0011;
        end
        default: begin
          laneEn = '1;
        end
      endcase
    end
  end

  // write data is lane aligned as on ahb
  always_ff @(posedge HCLK) begin
    for (int lane = 0; lane < LANES; lane++) begin
      if (laneEn[lane]) begin
        mem[idx][8*lane +: 8] <= bus.wdata[8*lane +: 8];
      end
    end
  end

  // full word read, master picks its bytes
  assign bus.rdata = mem[idx];

endmodule

// ==== hdl/ioPeripherals.sv ====
`timescale 1ns/1ps

module ioPeripherals (
  input  logic      HCLK,
  input  logic      arstN,
  slaveBus.ioSlave  bus,
  output logic      irq,
  output logic      fiq
);
  import ahbPkg::*;

  logic [REG_IDX_W-1:0] regIdx;
  logic                 wrEn;
  logic                 loadWr;
  logic                 statusWr;
  logic                 enableWr;
  logic                 fiqSelWr;
  logic                 softWr;

  logic [DATA_W-1:0]    timerCount;
  logic                 timerFire;

  logic [NUM_SRC-1:0]   status;
  logic [NUM_SRC-1:0]   enable;
  logic [NUM_SRC-1:0]   fiqSel;
  logic [NUM_SRC-1:0]   setMask;
  logic [NUM_SRC-1:0]   clrMask;

  // word offset within the io block
  assign regIdx = bus.addr[REG_IDX_W+1:2];

  // zero wait, writes land at this edge
  assign bus.ready = bus.sel;
  assign wrEn      = bus.sel && bus.write;

  assign loadWr   = wrEn && (regIdx == REG_TIMER_LOAD);
  assign statusWr = wrEn && (regIdx == REG_INT_STATUS);
  assign enableWr = wrEn && (regIdx == REG_INT_ENABLE);
  assign fiqSelWr = wrEn && (regIdx == REG_INT_FIQSEL);
  assign softWr   = wrEn && (regIdx == REG_SOFT_INT);

  // timer counts down to zero and stops
  always_ff @(posedge HCLK or negedge arstN) begin
    if (!arstN) begin
      timerCount <= '0;
    end else if (loadWr) begin
      timerCount <= bus.wdata;
    end else if (timerCount != '0) begin
      timerCount <= timerCount - 1'b1;
    end
  end

  // expiry on the 1 to 0 step
  // a reload in that cycle cancels it
  assign timerFire = (timerCount == DATA_W'(1)) && !loadWr;

  // set sources, software and timer
  always_comb begin
    setMask = softWr ? bus.wdata[NUM_SRC-1:0] : '0;
    setMask[SRC_TIMER] = setMask[SRC_TIMER] | timerFire;
  end

  // write one to clear
  assign clrMask = statusWr ? bus.wdata[NUM_SRC-1:0] : '0;

  always_ff @(posedge HCLK or negedge arstN) begin
    if (!arstN) begin
      status <= '0;
      enable <= '0;
      fiqSel <= '0;
    end else begin
      // set applied after clear so hardware wins
      status <= (status & ~clrMask) | setMask;
      if (enableWr) begin
        enable <= bus.wdata[NUM_SRC-1:0];
      end
      if (fiqSelWr) begin
        fiqSel <= bus.wdata[NUM_SRC-1:0];
      end
    end
  end

  // pending and enabled, split by fiq select
  assign irq = |(status & enable & ~fiqSel);
  assign fiq = |(status & enable & fiqSel);

  // register readback
  always_comb begin
    case (regIdx)
      REG_TIMER_VALUE: begin
        bus.rdata = timerCount;
      end
      REG_INT_STATUS: begin
        bus.rdata = DATA_W'(status);
      end
      REG_INT_ENABLE: begin
        bus.rdata = DATA_W'(enable);
      end
      REG_INT_FIQSEL: begin
        bus.rdata = DATA_W'(fiqSel);
      end
      default: begin
        // load, soft and unused offsets
        bus.rdata = '0;
      end
    endcase
  end

endmodule

// ==== hdl/ahbLite.sv ====
`timescale 1ns/1ps

module ahbLite #(
  parameter int MEM_WAIT  = 2,
  parameter int MEM_WORDS = 1024
) (
  input  logic                       HCLK,
  input  logic                       arstN,
  input  logic                       HREQUEST,
  input  ahbPkg::hsizeE              HSIZE,
  input  logic [ahbPkg::ADDR_W-1:0]  HADDR,
  input  logic [ahbPkg::DATA_W-1:0]  HWDATA,
  input  logic                       HWRITE,
  output logic [ahbPkg::DATA_W-1:0]  HRDATA,
  output logic                       HREADY,
  output logic                       irq,
  output logic                       fiq
);

  // one slave port per region
  slaveBus memBus ();
  slaveBus ioBus ();

  // memory sequencing strobes
  logic memLoad;
  logic memDone;
  logic memCommit;

  busRouter router (
    .HREQUEST(HREQUEST),
    .HWRITE  (HWRITE  ),
    .HSIZE   (HSIZE   ),
    .HADDR   (HADDR   ),
    .HWDATA  (HWDATA  ),
    .HRDATA  (HRDATA  ),
    .HREADY  (HREADY  ),
    .memBus  (memBus  ),
    .ioBus   (ioBus   )
  );

  // memory path
  memAccessFsm #(
    .MEM_WAIT(MEM_WAIT)
  ) memFsm (
    .HCLK  (HCLK     ),
    .arstN (arstN    ),
    .bus   (memBus   ),
    .load  (memLoad  ),
    .commit(memCommit),
    .done  (memDone  )
  );

  waitCounter #(
    .MEM_WAIT(MEM_WAIT)
  ) memWait (
    .HCLK (HCLK   ),
    .arstN(arstN  ),
    .load (memLoad),
    .done (memDone)
  );

  dataMem #(
    .MEM_WORDS(MEM_WORDS)
  ) mem (
    .HCLK  (HCLK     ),
    .commit(memCommit),
    .bus   (memBus   )
  );

  // timer and interrupt controller
  ioPeripherals io (
    .HCLK (HCLK ),
    .arstN(arstN),
    .bus  (ioBus),
    .irq  (irq  ),
    .fiq  (fiq  )
  );

endmodule

// ==== tests/ahbLiteTb.sv ====
`timescale 1ns/1ps

module ahbLiteTb;
  import ahbPkg::*;

  localparam int MEM_WAIT = 2;
  localparam int MEM_WORDS = 1024;
  localparam int MEM_BYTES = MEM_WORDS * 4;
  localparam logic [31:0] IO_BASE = 32'h8000_0000;
  // one full memory size up lands on the same word
  localparam logic [31:0] ALIAS = MEM_BYTES;

  typedef enum logic [1:0] {
    OP_WRITE,
    OP_READ,
    OP_IRQ,
    OP_TIMER
  } opE;

  // data holds the io write value or the timer load
  // expVal holds the io read value or {fiq, irq}
  typedef struct {
    opE          op;
    logic [31:0] addr;
    hsizeE       size;
    logic [31:0] data;
    logic [31:0] expVal;
  } rowT;

  logic        HCLK;
  logic        arstN;
  logic        HREQUEST;
  hsizeE       HSIZE;
  logic [31:0] HADDR;
  logic [31:0] HWDATA;
  logic        HWRITE;
  logic [31:0] HRDATA;
  logic        HREADY;
  logic        irq;
  logic        fiq;

  rowT        rows[$];
  // byte wide reference memory
  logic [7:0] refMem [MEM_BYTES];
  int         cycleCount = 0;
  int         timeoutLimit = 0;

  ahbLite u_dut (
    .HCLK    (HCLK    ),
    .arstN   (arstN   ),
    .HREQUEST(HREQUEST),
    .HSIZE   (HSIZE   ),
    .HADDR   (HADDR   ),
    .HWDATA  (HWDATA  ),
    .HWRITE  (HWRITE  ),
    .HRDATA  (HRDATA  ),
    .HREADY  (HREADY  ),
    .irq     (irq     ),
    .fiq     (fiq     )
  );

  always #50 HCLK = ~HCLK;

  // run limit in clock cycles
  always @(posedge HCLK) begin
    cycleCount++;
    if (cycleCount >= timeoutLimit) begin
      $display("timeout: transfers did not finish");
      $display("** FAIL **");
      $fatal(1, "run limit of %0d cycles reached", timeoutLimit);
    end
  end

  task automatic checkValue(input logic [31:0] actual, input logic [31:0] expected,
                            input string msg);
    if (actual !== expected) begin
      $display("CHECK FAILED at %0t ns: %s, got %h, expected %h", $time, msg, actual, expected);
      $display("** FAIL **");
      $fatal(1, "stopped at first mismatch");
    end
  endtask

  function automatic void addRow(opE op, logic [31:0] addr, hsizeE size, logic [31:0] data,
                                 logic [31:0] expVal);
    rowT r;
    r = '{op, addr, size, data, expVal};
    rows.push_back(r);
  endfunction

  function automatic logic [31:0] ioAddr(logic [REG_IDX_W-1:0] idx);
    return IO_BASE | (32'(idx) << 2);
  endfunction

  // lane aligned write into the model
  // address aliased to the memory size
  function automatic void refWrite(logic [31:0] addr, hsizeE size, logic [31:0] data);
    int base;
    int nBytes;
    nBytes = (size == SIZE_BYTE) ? 1 : (size == SIZE_HALF) ? 2 : 4;
    base = addr % MEM_BYTES;
    base = base - (base % nBytes);
    for (int i = 0; i < nBytes; i++) begin
      refMem[base + i] = data[8 * ((base + i) % 4) +: 8];
    end
  endfunction

  // whole word read with little endian lanes
  function automatic logic [31:0] refRead(logic [31:0] addr);
    int base;
    base = (addr % MEM_BYTES) & ~3;
    return {refMem[base + 3], refMem[base + 2], refMem[base + 1], refMem[base]};
  endfunction

  // one transfer entered 1 ns after a rising edge and left the same way
  task automatic transfer(input logic wr, input logic [31:0] addr, input hsizeE size,
                          input logic [31:0] wdata, output logic [31:0] rdata,
                          output int lowCycles);
    logic seenReady;
    HREQUEST = 1'b1;
    HWRITE = wr;
    HADDR = addr;
    HSIZE = size;
    HWDATA = wdata;
    lowCycles = 0;
    seenReady = 1'b0;
    // outputs are settled at the falling edge
    while (!seenReady) begin
      @(negedge HCLK);
      if (HREADY) begin
        seenReady = 1'b1;
      end else begin
        lowCycles++;
      end
    end
    rdata = HRDATA;
    @(posedge HCLK);
    #1;
    HREQUEST = 1'b0;
  endtask

  task automatic buildTable();
    // word path and aliasing
    addRow(OP_WRITE, 32'h0000_0100, SIZE_WORD, '0, '0);
    addRow(OP_WRITE, 32'h0000_0204, SIZE_WORD, '0, '0);
    addRow(OP_READ, 32'h0000_0100, SIZE_WORD, '0, '0);
    addRow(OP_READ, 32'h0000_0204, SIZE_WORD, '0, '0);
    addRow(OP_READ, 32'h0000_0100 + ALIAS, SIZE_WORD, '0, '0);
    addRow(OP_WRITE, 32'h0000_0204 + ALIAS, SIZE_WORD, '0, '0);
    addRow(OP_READ, 32'h0000_0204, SIZE_WORD, '0, '0);
    addRow(OP_IRQ, '0, SIZE_WORD, '0, 32'h0);
    // byte and halfword lanes over a known word
    addRow(OP_WRITE, 32'h0000_0300, SIZE_WORD, '0, '0);
    addRow(OP_WRITE, 32'h0000_0301, SIZE_BYTE, '0, '0);
    addRow(OP_WRITE, 32'h0000_0302, SIZE_HALF, '0, '0);
    addRow(OP_READ, 32'h0000_0300, SIZE_WORD, '0, '0);
    addRow(OP_WRITE, 32'h0000_0304, SIZE_WORD, '0, '0);
    addRow(OP_WRITE, 32'h0000_0307, SIZE_BYTE, '0, '0);
    addRow(OP_WRITE, 32'h0000_0304, SIZE_HALF, '0, '0);
    addRow(OP_READ, 32'h0000_0304, SIZE_BYTE, '0, '0);
    addRow(OP_WRITE, 32'h0000_0300 + ALIAS, SIZE_BYTE, '0, '0);
    addRow(OP_READ, 32'h0000_0300, SIZE_WORD, '0, '0);
    // soft interrupt on source 3 masked first
    addRow(OP_IRQ, '0, SIZE_WORD, '0, 32'h0);
    addRow(OP_WRITE, ioAddr(REG_SOFT_INT), SIZE_WORD, 32'h08, '0);
    addRow(OP_READ, ioAddr(REG_INT_STATUS), SIZE_WORD, '0, 32'h08);
    addRow(OP_IRQ, '0, SIZE_WORD, '0, 32'h0);
    addRow(OP_WRITE, ioAddr(REG_INT_ENABLE), SIZE_WORD, 32'h08, '0);
    addRow(OP_IRQ, '0, SIZE_WORD, '0, 32'h1);
    addRow(OP_WRITE, ioAddr(REG_INT_FIQSEL), SIZE_WORD, 32'h08, '0);
    addRow(OP_IRQ, '0, SIZE_WORD, '0, 32'h2);
    addRow(OP_WRITE, ioAddr(REG_INT_STATUS), SIZE_WORD, 32'h08, '0);
    addRow(OP_IRQ, '0, SIZE_WORD, '0, 32'h0);
    addRow(OP_READ, ioAddr(REG_INT_STATUS), SIZE_WORD, '0, 32'h0);
    // timer on irq
    addRow(OP_WRITE, ioAddr(REG_INT_ENABLE), SIZE_WORD, 32'h01, '0);
    addRow(OP_WRITE, ioAddr(REG_TIMER_LOAD), SIZE_WORD, 32'd20, '0);
    addRow(OP_TIMER, '0, SIZE_WORD, 32'd20, '0);
    addRow(OP_IRQ, '0, SIZE_WORD, '0, 32'h1);
    addRow(OP_READ, ioAddr(REG_TIMER_VALUE), SIZE_WORD, '0, 32'h0);
    addRow(OP_WRITE, ioAddr(REG_INT_STATUS), SIZE_WORD, 32'h01, '0);
    addRow(OP_IRQ, '0, SIZE_WORD, '0, 32'h0);
  endtask

  initial begin
    logic [31:0] rdata;
    logic [31:0] wdata;
    logic [31:0] prevCount;
    logic        isMem;
    logic        fired;
    int          lowCycles;
    int          polls;
    int          maxLoad;
    // single seed for the whole run
    void'($urandom(32'h395cf96c));
    HCLK = 1'b0;
    arstN = 1'b0;
    HREQUEST = 1'b0;
    HWRITE = 1'b0;
    HSIZE = SIZE_WORD;
    HADDR = '0;
    HWDATA = '0;
    buildTable();
    maxLoad = 0;
    foreach (rows[i]) begin
      if (rows[i].op == OP_TIMER && rows[i].data > maxLoad) begin
        maxLoad = rows[i].data;
      end
    end
    timeoutLimit = rows.size() * (MEM_WAIT + 2) + maxLoad + 50;
    repeat (2) @(posedge HCLK);
    #1;
    arstN = 1'b1;
    @(posedge HCLK);
    #1;
    foreach (rows[i]) begin
      isMem = !rows[i].addr[REGION_BIT];
      case (rows[i].op)
        OP_WRITE: begin
          wdata = isMem ? $urandom : rows[i].data;
          transfer(1'b1, rows[i].addr, rows[i].size, wdata, rdata, lowCycles);
          if (isMem) begin
            refWrite(rows[i].addr, rows[i].size, wdata);
          end
          checkValue(lowCycles, isMem ? MEM_WAIT + 1 : 0,
                     $sformatf("row %0d write wait cycles", i));
        end
        OP_READ: begin
          transfer(1'b0, rows[i].addr, rows[i].size, '0, rdata, lowCycles);
          checkValue(lowCycles, isMem ? MEM_WAIT + 1 : 0,
                     $sformatf("row %0d read wait cycles", i));
          checkValue(rdata, isMem ? refRead(rows[i].addr) : rows[i].expVal,
                     $sformatf("row %0d read data", i));
        end
        OP_IRQ: begin
          // bus idle for one cycle
          @(negedge HCLK);
          checkValue(HREADY, 1'b1, $sformatf("row %0d HREADY while idle", i));
          checkValue(HRDATA, '0, $sformatf("row %0d HRDATA while idle", i));
          checkValue({fiq, irq}, rows[i].expVal, $sformatf("row %0d {fiq, irq}", i));
          @(posedge HCLK);
          #1;
        end
        OP_TIMER: begin
          prevCount = rows[i].data;
          polls = 0;
          fired = 1'b0;
          // poll count then status in two cycles a round
          while (!fired) begin
            transfer(1'b0, ioAddr(REG_TIMER_VALUE), SIZE_WORD, '0, rdata, lowCycles);
            checkValue(lowCycles, 0, $sformatf("row %0d count poll wait cycles", i));
            checkValue(rdata <= prevCount, 1'b1, $sformatf("row %0d timer count rose", i));
            prevCount = rdata;
            transfer(1'b0, ioAddr(REG_INT_STATUS), SIZE_WORD, '0, rdata, lowCycles);
            checkValue(lowCycles, 0, $sformatf("row %0d status poll wait cycles", i));
            fired = rdata[SRC_TIMER];
            polls++;
          end
          checkValue(2 * polls <= rows[i].data + 4, 1'b1,
                     $sformatf("row %0d timer expiry late", i));
        end
        default: begin
        end
      endcase
    end
    $display("** PASS **");
    $finish;
  end

endmodule

// ==== files.f ====
hdl/ahbPkg.sv
hdl/slaveBus.sv
hdl/busRouter.sv
hdl/memAccessFsm.sv
hdl/waitCounter.sv
hdl/dataMem.sv
hdl/ioPeripherals.sv
hdl/ahbLite.sv
tests/ahbLiteTb.sv

// ==== Bender.yml ====
package:
  name: ahb_lite

sources:
  - hdl/ahbPkg.sv
  - hdl/slaveBus.sv
  - hdl/busRouter.sv
  - hdl/memAccessFsm.sv
  - hdl/waitCounter.sv
  - hdl/dataMem.sv
  - hdl/ioPeripherals.sv
  - hdl/ahbLite.sv
  - target: test
    files:
      - tests/ahbLiteTb.sv
